// ==== source/keccak_params.svh ====
`ifndef KECCAK_PARAMS_SVH
`define KECCAK_PARAMS_SVH

// Keccak-f[1600] geometry.

// Bits per lane.
`define KECCAK_LANE_W 64
// Lanes per row and per column.
`define KECCAK_DIM 5
// Compressed round constant, seven bits.
`define KECCAK_RC_W 7
// Whole state, 25 lanes.
`define KECCAK_STATE_W 1600

`endif

// ==== source/keccak_pkg.sv ====
`include "keccak_params.svh"

package keccak_pkg;

  // ----------------------------------------
  // State layout
  // ----------------------------------------

  // One lane of the state.
  typedef logic [`KECCAK_LANE_W-1:0] lane_t;

  // Five lanes by x, lane x = 0 in the top bits.
  typedef lane_t [0:`KECCAK_DIM-1] plane_t;

  // Five planes by y, so lane (0,0) sits at bits 1599:1536
  // and lane (4,4) at bits 63:0.
  typedef plane_t [0:`KECCAK_DIM-1] state_t;

  // Compressed round constant.
  typedef logic [`KECCAK_RC_W-1:0] rc_t;

  // ----------------------------------------
  // Registered output
  // ----------------------------------------

  // Result word with its strobe.
  typedef struct packed {
    logic   valid;
    state_t state;
  } beat_t;

endpackage

// ==== source/keccak_theta.sv ====
`timescale 1ns/10ps

`include "keccak_params.svh"

module keccak_theta (
  input  keccak_pkg::state_t state_in,
  output keccak_pkg::state_t state_out
);

  // ----------------------------------------
  // Column parity
  // ----------------------------------------

  keccak_pkg::plane_t parity; // One parity lane per column x.

  always_comb begin
    for (int x = 0; x < `KECCAK_DIM; x++) begin
      parity[x] = '0;
      for (int y = 0; y < `KECCAK_DIM; y++) begin
        parity[x] = parity[x] ^ state_in[y][x];
      end
    end
  end

  // ----------------------------------------
  // Mixing
  // ----------------------------------------

  // Each lane picks up the parity of the column to its left and the
  // parity of the column to its right rotated by one bit.
  always_comb begin
    for (int y = 0; y < `KECCAK_DIM; y++) begin
      for (int x = 0; x < `KECCAK_DIM; x++) begin
        state_out[y][x] = state_in[y][x]
                        ^ parity[(x + `KECCAK_DIM - 1) % `KECCAK_DIM] // Column x-1.
                        ^ {parity[(x + 1) % `KECCAK_DIM][`KECCAK_LANE_W-2:0],
                           parity[(x + 1) % `KECCAK_DIM][`KECCAK_LANE_W-1]};
      end
    end
  end

endmodule

// ==== source/keccak_rho_pi.sv ====
`timescale 1ns/10ps

`include "keccak_params.svh"

module keccak_rho_pi (
  input  keccak_pkg::state_t state_in,
  output keccak_pkg::state_t state_out
);

  // ----------------------------------------
  // Rho offsets
  // ----------------------------------------

  // Left rotation per lane, rows by y, entries by x.
  localparam int unsigned RHO_OFS [0:`KECCAK_DIM-1][0:`KECCAK_DIM-1] = '{
    '{ 0,  1, 62, 28, 27},
    '{36, 44,  6, 55, 20},
    '{ 3, 10, 43, 25, 39},
    '{41, 45, 15, 21,  8},
    '{18,  2, 61, 56, 14}
  };

  // Rotate a lane left by n bits.
  function automatic keccak_pkg::lane_t rotl(
    input keccak_pkg::lane_t v,
    input int unsigned       n
  );
    keccak_pkg::lane_t r;
    r = (v << n) | (v >> ((`KECCAK_LANE_W - n) % `KECCAK_LANE_W));
    return r;
  endfunction

  // ----------------------------------------
  // Rho
  // ----------------------------------------

  keccak_pkg::state_t rotated; // Lanes after rho, still in place.

  always_comb begin
    for (int y = 0; y < `KECCAK_DIM; y++) begin
      for (int x = 0; x < `KECCAK_DIM; x++) begin
        rotated[y][x] = rotl(state_in[y][x], RHO_OFS[y][x]);
      end
    end
  end

  // ----------------------------------------
  // Pi
  // ----------------------------------------

  // Lane (x,y) lands at (y, 2x+3y mod 5).
  always_comb begin
    for (int y = 0; y < `KECCAK_DIM; y++) begin
      for (int x = 0; x < `KECCAK_DIM; x++) begin
        state_out[(2 * x + 3 * y) % `KECCAK_DIM][y] = rotated[y][x];
      end
    end
  end

endmodule

// ==== source/keccak_chi_iota.sv ====
`timescale 1ns/10ps

`include "keccak_params.svh"

module keccak_chi_iota (
  input  keccak_pkg::state_t state_in,
  input  keccak_pkg::rc_t    rc,
  output keccak_pkg::state_t state_out
);

  // ----------------------------------------
  // Chi
  // ----------------------------------------

  keccak_pkg::state_t chi_s; // Rows after the nonlinear step.

  // Works along each row of five lanes, wrapping at x = 4.
  always_comb begin
    for (int y = 0; y < `KECCAK_DIM; y++) begin
      for (int x = 0; x < `KECCAK_DIM; x++) begin
        chi_s[y][x] = state_in[y][x]
                    ^ (~state_in[y][(x + 1) % `KECCAK_DIM]
                       & state_in[y][(x + 2) % `KECCAK_DIM]);
      end
    end
  end

  // ----------------------------------------
  // Iota
  // ----------------------------------------

  // Lane bit that each rc bit expands to, rc bit 0 first.
  localparam int unsigned RC_POS [0:`KECCAK_RC_W-1] = '{0, 1, 3, 7, 15, 31, 63};

  keccak_pkg::lane_t rc_lane; // Expanded round constant.

  always_comb begin
    rc_lane = '0;
    for (int i = 0; i < `KECCAK_RC_W; i++) begin
      rc_lane[RC_POS[i]] = rc[i];
    end
  end

  // Only lane (0,0) takes the constant.
  always_comb begin
    state_out       = chi_s;
    state_out[0][0] = chi_s[0][0] ^ rc_lane;
  end

endmodule

// ==== source/keccak_round.sv ====
`timescale 1ns/10ps

`include "keccak_params.svh"

module keccak_round (
  input  keccak_pkg::state_t state_in,
  input  keccak_pkg::rc_t    rc,
  output keccak_pkg::state_t state_out
);

  // Intermediate states between the steps.
  keccak_pkg::state_t theta_s;
  keccak_pkg::state_t rho_pi_s;

  // ----------------------------------------
  // Step chain
  // ----------------------------------------

  // Column mixing.
  keccak_theta i_keccak_theta (
    .state_in  (state_in),
    .state_out (theta_s)
  );

  // Lane rotation and permutation.
  keccak_rho_pi i_keccak_rho_pi (
    .state_in  (theta_s),
    .state_out (rho_pi_s)
  );

  // Row nonlinearity and round constant.
  keccak_chi_iota i_keccak_chi_iota (
    .state_in  (rho_pi_s),
    .rc        (rc),
    .state_out (state_out)
  );

endmodule

// ==== source/keccak_double_round.sv ====
`timescale 1ns/10ps

`include "keccak_params.svh"

module keccak_double_round (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               in_valid,
  input  keccak_pkg::state_t state_in,
  input  keccak_pkg::rc_t    rc1,
  input  keccak_pkg::rc_t    rc2,
  output logic               out_valid,
  output keccak_pkg::state_t state_out
);

  keccak_pkg::beat_t  beat_d; // Next register content.
  keccak_pkg::beat_t  beat_q;
  keccak_pkg::state_t round1_s; // Between the two rounds.

  // ----------------------------------------
  // Inputs
  // ----------------------------------------

  assign beat_d.valid = in_valid; // Strobe rides along with the result.

  // ----------------------------------------
  // Rounds
  // ----------------------------------------

  keccak_round i_keccak_round_1 (
    .state_in  (state_in),
    .rc        (rc1),
    .state_out (round1_s)
  );

  keccak_round i_keccak_round_2 (
    .state_in  (round1_s),
    .rc        (rc2),
    .state_out (beat_d.state)
  );

  // ----------------------------------------
  // Output register
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      beat_q <= '{valid: 1'b0, state: {`KECCAK_STATE_W{1'b0}}};
    end else begin
      beat_q.valid <= beat_d.valid;
      if (beat_d.valid) beat_q.state <= beat_d.state; // Holds through gaps.
    end
  end

  assign out_valid = beat_q.valid;
  assign state_out = beat_q.state;

endmodule

// ==== tb/keccak_checker.sv ====
`timescale 1ns/10ps

`include "keccak_params.svh"

module keccak_checker (
  input logic               clk,
  input logic               rst_n,
  input logic               in_valid,
  input keccak_pkg::state_t state_in,
  input keccak_pkg::rc_t    rc1,
  input keccak_pkg::rc_t    rc2,
  input logic               out_valid,
  input keccak_pkg::state_t state_out
);

  typedef logic [`KECCAK_LANE_W-1:0]  word_t;
  typedef logic [`KECCAK_STATE_W-1:0] flat_t;

  int    error_count = 0;
  int    compared    = 0;
  string test_name   = "reset";
  string next_name   = "reset"; // Takes over at the next edge.
  flat_t exp_q[$];          // Expected results, oldest first.
  string name_q[$];         // Test that sent each entry.
  int    rho_ofs[25];       // Indexed by x + 5y.
  logic  rst_q       = 1'b1; // rst_n seen at the previous edge.
  flat_t last_out    = '0;   // state_out seen at the previous edge.

  // ----------------------------------------
  // Reference model
  // ----------------------------------------

  // Rho offsets from the triangular-number walk over the lanes.
  initial begin : build_rho
    int x;
    int y;
    int nx;
    x = 1;
    y = 0;
    rho_ofs[0] = 0;
    for (int t = 0; t < 24; t++) begin
      rho_ofs[x + 5 * y] = ((t + 1) * (t + 2) / 2) % 64;
      nx = y;
      y  = (2 * x + 3 * y) % 5;
      x  = nx;
    end
  end

  function automatic word_t rotate_left(input word_t v, input int n);
    word_t r;
    if (n == 0) r = v;
    else r = (v << n) | (v >> (64 - n));
    return r;
  endfunction

  // One round on the flat state, lane (x,y) at index x + 5y from the top.
  function automatic flat_t apply_round(input flat_t s, input keccak_pkg::rc_t rc);
    word_t a[25];
    word_t b[25];
    word_t c[5];
    word_t d[5];
    flat_t r;
    for (int i = 0; i < 25; i++) a[i] = s[`KECCAK_STATE_W-1-64*i -: 64];
    // Theta.
    for (int x = 0; x < 5; x++) c[x] = a[x] ^ a[x+5] ^ a[x+10] ^ a[x+15] ^ a[x+20];
    for (int x = 0; x < 5; x++) d[x] = c[(x + 4) % 5] ^ rotate_left(c[(x + 1) % 5], 1);
    for (int i = 0; i < 25; i++) a[i] = a[i] ^ d[i % 5];
    // Rho and pi.
    for (int y = 0; y < 5; y++) begin
      for (int x = 0; x < 5; x++) begin
        b[y + 5 * ((2 * x + 3 * y) % 5)] = rotate_left(a[x + 5 * y], rho_ofs[x + 5 * y]);
      end
    end
    // Chi.
    for (int y = 0; y < 5; y++) begin
      for (int x = 0; x < 5; x++) begin
        a[x + 5 * y] = b[x + 5 * y] ^ (~b[(x + 1) % 5 + 5 * y] & b[(x + 2) % 5 + 5 * y]);
      end
    end
    // Iota, rc bit j lands on lane bit 2^j - 1.
    for (int j = 0; j < 7; j++) a[0][(1 << j) - 1] = a[0][(1 << j) - 1] ^ rc[j];
    for (int i = 0; i < 25; i++) r[`KECCAK_STATE_W-1-64*i -: 64] = a[i];
    return r;
  endfunction

  function automatic flat_t apply_double_round(input flat_t s, input keccak_pkg::rc_t r1,
                                               input keccak_pkg::rc_t r2);
    return apply_round(apply_round(s, r1), r2);
  endfunction

  // ----------------------------------------
  // Reporting
  // ----------------------------------------

  // The last input of the previous test is still sampled at the next edge.
  task automatic set_test(input string name);
    next_name = name;
  endtask

  // Shows the first lane that differs.
  task automatic report_mismatch(input string name, input flat_t exp_s, input flat_t act_s);
    int lane;
    lane = 0;
    for (int i = 24; i >= 0; i--) begin
      if (exp_s[`KECCAK_STATE_W-1-64*i -: 64] !== act_s[`KECCAK_STATE_W-1-64*i -: 64]) lane = i;
    end
    $display("** Error %s: lane (%0d,%0d) expected %h actual %h", name, lane % 5, lane / 5,
             exp_s[`KECCAK_STATE_W-1-64*lane -: 64], act_s[`KECCAK_STATE_W-1-64*lane -: 64]);
    error_count++;
  endtask

  task automatic check_drained();
    if (exp_q.size() != 0) begin
      $display("Checker: %0d results never came out at the end of the run", exp_q.size());
      error_count++;
    end
  endtask

  // ----------------------------------------
  // Compare
  // ----------------------------------------

  always @(posedge clk) begin
    flat_t exp_s;
    string exp_name;
    if (!rst_q) begin // Register was cleared at the last edge.
      if (out_valid !== 1'b0) begin
        $display("Checker: out_valid was high in the cycle after reset");
        error_count++;
      end
      if (state_out !== '0) report_mismatch("reset", '0, state_out);
    end
    if (!rst_n) begin
      exp_q.delete();
      name_q.delete();
    end else begin
      if (out_valid === 1'b1) begin
        if (exp_q.size() == 0) begin
          $display("Checker: out_valid was high with no input pending in test %s", test_name);
          error_count++;
        end else begin
          exp_s    = exp_q.pop_front();
          exp_name = name_q.pop_front();
          compared++;
          if (state_out !== exp_s) report_mismatch(exp_name, exp_s, state_out);
        end
      end else begin
        if (exp_q.size() != 0) begin
          $display("Checker: result for test %s did not appear one cycle after its input",
                   name_q[0]);
          error_count++;
          exp_q.delete();
          name_q.delete();
        end
        // Gap cycle, the last result stays on state_out.
        if (rst_q && state_out !== last_out) begin
          $display("Checker: state_out changed while out_valid was low in test %s",
                   test_name);
          error_count++;
        end
      end
      if (in_valid) begin
        exp_q.push_back(apply_double_round(state_in, rc1, rc2));
        name_q.push_back(test_name);
      end
    end
    rst_q     = rst_n;
    last_out  = state_out;
    test_name = next_name;
  end

endmodule

// ==== tb/keccak_double_round_sva.sv ====
`timescale 1ns/10ps

module keccak_double_round_sva (
  input logic               clk,
  input logic               rst_n,
  input logic               in_valid,
  input logic               out_valid,
  input keccak_pkg::state_t state_out
);

  int assert_failures = 0; // Summed into the final error count.

  // ----------------------------------------
  // Output strobe
  // ----------------------------------------

  reset_clears_valid: assert property (@(posedge clk) !rst_n |=> !out_valid)
    else begin
      $error("out_valid high in the cycle after reset");
      assert_failures++;
    end

  valid_follows_input: assert property (@(posedge clk) disable iff (!rst_n)
    $past(rst_n) |-> out_valid == $past(in_valid))
    else begin
      $error("out_valid does not match in_valid of the previous cycle");
      assert_failures++;
    end

  // Result must be fully known while presented.
  state_known: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> !$isunknown(state_out))
    else begin
      $error("state_out has unknown bits while out_valid is high");
      assert_failures++;
    end

endmodule

bind keccak_double_round keccak_double_round_sva i_keccak_double_round_sva (.*);

// ==== tb/tb_keccak_double_round.sv ====
`timescale 1ns/10ps

`include "keccak_params.svh"

module tb_keccak_double_round;

  localparam int unsigned SEED       = 32'h9d0d_2e87;
  localparam int          MAX_CYCLES = 1000; // Roughly 400 cycles of tests.

  logic               clk = 1'b0;
  logic               rst_n;
  logic               in_valid;
  keccak_pkg::state_t state_in;
  keccak_pkg::rc_t    rc1;
  keccak_pkg::rc_t    rc2;
  logic               out_valid;
  keccak_pkg::state_t state_out;
  int                 cycles = 0;
  int unsigned        seed_ret;

  always #2 clk = ~clk; // 4 ns period.

  // ----------------------------------------
  // DUT and checker
  // ----------------------------------------

  keccak_double_round i_keccak_double_round (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .state_in  (state_in),
    .rc1       (rc1),
    .rc2       (rc2),
    .out_valid (out_valid),
    .state_out (state_out)
  );

  keccak_checker i_keccak_checker (.*);

  // Run limit.
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------

  function automatic keccak_pkg::state_t random_state();
    logic [`KECCAK_STATE_W-1:0] f;
    for (int i = 0; i < `KECCAK_STATE_W / 32; i++) f[32*i +: 32] = $urandom();
    return f;
  endfunction

  // Inputs change shortly after the edge.
  task automatic drive(input logic v, input keccak_pkg::state_t s,
                       input keccak_pkg::rc_t r1, input keccak_pkg::rc_t r2);
    @(posedge clk);
    #0.5;
    in_valid = v;
    state_in = s;
    rc1      = r1;
    rc2      = r2;
  endtask

  // gap_pct is the rough share of idle cycles.
  task automatic random_traffic(input int n, input int gap_pct);
    for (int i = 0; i < n; i++) begin
      drive($urandom_range(99) >= gap_pct, random_state(),
            keccak_pkg::rc_t'($urandom()), keccak_pkg::rc_t'($urandom()));
    end
  endtask

  initial begin
    keccak_pkg::state_t s;
    int                 total;
    seed_ret = $urandom(SEED);
    rst_n    = 1'b0;
    in_valid = 1'b0;
    state_in = '0;
    rc1      = '0;
    rc2      = '0;
    repeat (3) @(posedge clk);
    #0.5;
    rst_n = 1'b1;

    i_keccak_checker.set_test("zero_state");
    drive(1'b1, '0, 7'h01, 7'h1A);
    repeat (9) drive(1'b0, '0, '0, '0);

    i_keccak_checker.set_test("back_to_back");
    random_traffic(200, 0);

    i_keccak_checker.set_test("gaps");
    random_traffic(150, 30);

    i_keccak_checker.set_test("const_isolation");
    s = random_state();
    drive(1'b1, s, 7'h00, 7'h00);
    drive(1'b1, s, 7'h55, 7'h7F);
    drive(1'b0, '0, '0, '0);

    // Reset lands on the next three edges while traffic keeps coming.
    i_keccak_checker.set_test("mid_reset");
    random_traffic(10, 20);
    rst_n = 1'b0;
    random_traffic(3, 0);
    rst_n = 1'b1;
    random_traffic(20, 30);
    repeat (3) drive(1'b0, '0, '0, '0);

    i_keccak_checker.check_drained();
    total = i_keccak_checker.error_count
          + i_keccak_double_round.i_keccak_double_round_sva.assert_failures;
    $display("Compared %0d results, %0d checker errors, %0d assertion failures",
             i_keccak_checker.compared, i_keccak_checker.error_count,
             i_keccak_double_round.i_keccak_double_round_sva.assert_failures);
    if (total == 0) $display("STATUS: PASS");
    else $display("STATUS: FAIL");
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+source
source/keccak_pkg.sv
source/keccak_theta.sv
source/keccak_rho_pi.sv
source/keccak_chi_iota.sv
source/keccak_round.sv
source/keccak_double_round.sv
tb/keccak_checker.sv
tb/keccak_double_round_sva.sv
tb/tb_keccak_double_round.sv
